/* src/conv_pkg.sv */
package conv_pkg;

    localparam int ROW_IN     = 16;
    localparam int OUT_ROW    = 14;
    localparam int FRAME_ROWS = 4;
    localparam int OUT_DEPTH  = OUT_ROW * FRAME_ROWS;
    localparam int ADDR_W     = 6;
    localparam int PSUM_W     = 32;
    localparam int OUT_W      = 16;

    localparam logic [1:0] ADR_KERNEL = 2'd0;
    localparam logic [1:0] ADR_ROW    = 2'd1;
    localparam logic [1:0] ADR_PIXELS = 2'd2;
    localparam logic [1:0] ADR_STATUS = 2'd3;

    // Bus views of one write-data word
    typedef struct packed {
        logic signed [7:0] bias;
        logic signed [7:0] w2;
        logic signed [7:0] w1;
        logic signed [7:0] w0;
    } kernel_word_t;

    // Pixel 0 sits in the low byte and enters first
    typedef struct packed {
        logic signed [7:0] p3;
        logic signed [7:0] p2;
        logic signed [7:0] p1;
        logic signed [7:0] p0;
    } pixel_word_t;

    typedef struct packed {
        logic [28:0] pad;
        logic        last_channel;
        logic        first_channel;
        logic        last_row;
    } row_cmd_t;

    typedef union packed {
        kernel_word_t kernel;
        row_cmd_t     row;
        pixel_word_t  pixels;
    } bus_word_u;

    typedef struct packed {
        logic signed [7:0] bias;
        logic signed [7:0] w2;
        logic signed [7:0] w1;
        logic signed [7:0] w0;
    } kernel_t;

    typedef struct packed {
        logic last_channel;
        logic first_channel;
        logic last_row;
    } row_mode_t;

    typedef struct packed {
        logic signed [7:0] data;
        logic              valid;
    } pixel_beat_t;

    typedef struct packed {
        logic signed [PSUM_W-1:0] psum;
        logic                     valid;
        logic                     done_row;
    } mac_out_t;

    typedef struct packed {
        logic [OUT_W-1:0] data;
        logic             valid;
        logic             last;
    } stream_word_t;

    typedef struct packed {
        logic [28:0] pad;
        logic        busy;
        logic        pe_ready_seen;
        logic        idle;
    } status_t;

endpackage

/* src/wb_cmd_port.sv */
`timescale 1ns/1ps

module wb_cmd_port
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  bus_word_u   wb_dat_i,
    output status_t     wb_dat_o,
    output logic        wb_ack,
    input  logic        idle,
    input  logic        pe_ready,
    output logic        load_kernel,
    output logic        stream_row,
    output row_mode_t   row_mode,
    output kernel_t     kernel,
    output pixel_beat_t pixel
);

    logic              req;
    logic              kernel_acc;
    logic              row_acc;
    logic              pixel_acc;
    logic              other_acc;
    logic              accept;
    logic [2:0]        pix_left;
    logic signed [7:0] slot [4];
    logic              pe_ready_seen;
    status_t           status;

    // A request is pending until it is acknowledged
    assign req = wb_cyc && wb_stb && !wb_ack;

    assign kernel_acc = req && wb_we && (wb_adr == ADR_KERNEL) && idle;
    assign row_acc    = req && wb_we && (wb_adr == ADR_ROW) && idle;
    assign pixel_acc  = req && wb_we && (wb_adr == ADR_PIXELS) && (pix_left == 3'd0);
    // Reads and stray status writes complete at once
    assign other_acc  = req && (!wb_we || (wb_adr == ADR_STATUS));
    assign accept     = kernel_acc || row_acc || pixel_acc || other_acc;

    assign status = '{
        pad:           '0,
        busy:          !idle || (pix_left != 3'd0),
        pe_ready_seen: pe_ready_seen,
        idle:          idle
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack        <= 1'b0;
            load_kernel   <= 1'b0;
            stream_row    <= 1'b0;
            row_mode      <= '0;
            pe_ready_seen <= 1'b0;
        end else begin
            wb_ack      <= accept;
            load_kernel <= kernel_acc;
            stream_row  <= row_acc;
            if (row_acc) begin
                row_mode.last_row      <= wb_dat_i.row.last_row;
                row_mode.first_channel <= wb_dat_i.row.first_channel;
                row_mode.last_channel  <= wb_dat_i.row.last_channel;
            end
            if (pe_ready) begin
                pe_ready_seen <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (kernel_acc) begin
            kernel <= wb_dat_i.kernel;
        end
        if (other_acc) begin
            wb_dat_o <= status;
        end
    end

    // Unpacker, one pixel per cycle from slot 0
    always_ff @(posedge clk) begin
        if (reset) begin
            pix_left <= '0;
        end else if (pixel_acc) begin
            pix_left <= 3'd4;
        end else if (pix_left != 3'd0) begin
            pix_left <= pix_left - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (pixel_acc) begin
            slot[0] <= wb_dat_i.pixels.p0;
            slot[1] <= wb_dat_i.pixels.p1;
            slot[2] <= wb_dat_i.pixels.p2;
            slot[3] <= wb_dat_i.pixels.p3;
        end else begin
            slot[0] <= slot[1];
            slot[1] <= slot[2];
            slot[2] <= slot[3];
        end
    end

    assign pixel = '{data: slot[0], valid: (pix_left != 3'd0)};

endmodule

/* src/row_mac.sv */
`timescale 1ns/1ps

module row_mac
    import conv_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  pixel_beat_t pixel,
    input  kernel_t     kernel,
    input  logic        stream_row,
    output mac_out_t    mac
);

    logic signed [7:0]        win_old;
    logic signed [7:0]        win_mid;
    logic [4:0]               pix_count;
    logic                     take;
    logic signed [PSUM_W-1:0] psum_q;
    logic                     valid_q;
    logic                     done_q;

    // Pixels past the end of the row are dropped
    assign take = pixel.valid && (pix_count < 5'(ROW_IN));

    always_ff @(posedge clk) begin
        if (reset || stream_row) begin
            pix_count <= '0;
        end else if (take) begin
            pix_count <= pix_count + 5'd1;
        end
    end

    // Two oldest pixels of the window; the incoming one is the third
    always_ff @(posedge clk) begin
        if (stream_row) begin
            win_old <= '0;
            win_mid <= '0;
        end else if (take) begin
            win_old <= win_mid;
            win_mid <= pixel.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            valid_q <= take && (pix_count >= 5'd2);
            done_q  <= take && (pix_count == 5'(ROW_IN - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            psum_q <= kernel.w0 * win_old + kernel.w1 * win_mid + kernel.w2 * pixel.data;
        end
    end

    assign mac = '{psum: psum_q, valid: valid_q, done_row: done_q};

endmodule

/* src/pe_buffer_ctrl.sv */
`timescale 1ns/1ps

module pe_buffer_ctrl
    import conv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      load_kernel,
    input  logic      stream_row,
    input  row_mode_t row_mode,
    input  mac_out_t  mac,
    output logic      idle,
    output logic      pe_ready,
    output logic      wr_en,
    output logic      add_bias,
    output logic      addr_clear,
    output logic      emit,
    output logic      emit_last
);

    typedef enum logic [3:0] {
        S_RESET,
        S_IDLE,
        S_LOAD_KERNEL,
        S_PE_READY,
        S_WAIT_MID,
        S_WRITE_MID,
        S_WAIT_LAST,
        S_WRITE_LAST,
        S_CLEAR_ADDR
    } state_t;

    state_t state;
    state_t state_next;
    logic   row_end;
    logic   in_row;
    logic   in_last_row;

    // Final result of the row
    assign row_end = mac.valid && mac.done_row;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            S_RESET: state_next = S_IDLE;

            S_IDLE: begin
                if (load_kernel) begin
                    state_next = S_LOAD_KERNEL;
                end else if (stream_row) begin
                    state_next = row_mode.last_row ? S_WAIT_LAST : S_WAIT_MID;
                end
            end

            S_LOAD_KERNEL: state_next = S_PE_READY;

            S_PE_READY: state_next = S_IDLE;

            S_WAIT_MID, S_WRITE_MID: begin
                if (row_end) begin
                    state_next = S_IDLE;
                end else if (mac.valid) begin
                    state_next = S_WRITE_MID;
                end else begin
                    state_next = S_WAIT_MID;
                end
            end

            // Last row of the frame ends with an address clear
            S_WAIT_LAST, S_WRITE_LAST: begin
                if (row_end) begin
                    state_next = S_CLEAR_ADDR;
                end else if (mac.valid) begin
                    state_next = S_WRITE_LAST;
                end else begin
                    state_next = S_WAIT_LAST;
                end
            end

            S_CLEAR_ADDR: state_next = S_IDLE;

            default: state_next = S_IDLE;
        endcase
    end

    assign in_last_row = (state == S_WAIT_LAST) || (state == S_WRITE_LAST);
    assign in_row      = in_last_row || (state == S_WAIT_MID) || (state == S_WRITE_MID);

    assign idle       = (state == S_IDLE);
    assign pe_ready   = (state == S_PE_READY);
    assign wr_en      = in_row && mac.valid;
    assign add_bias   = in_row && row_mode.first_channel;
    assign addr_clear = (state == S_CLEAR_ADDR);
    // Stream only on the last channel, last flag with the 56th write
    assign emit       = wr_en && row_mode.last_channel;
    assign emit_last  = emit && in_last_row && mac.done_row;

endmodule

/* src/psum_buffer.sv */
`timescale 1ns/1ps

module psum_buffer
    import conv_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  mac_out_t                 mac,
    input  kernel_t                  kernel,
    input  logic                     wr_en,
    input  logic                     add_bias,
    input  logic                     addr_clear,
    input  logic                     emit,
    input  logic                     emit_last,
    output logic signed [PSUM_W-1:0] sum,
    output logic                     sum_valid,
    output logic                     sum_last
);

    logic signed [PSUM_W-1:0] mem [OUT_DEPTH];
    logic [ADDR_W-1:0]        addr;
    logic signed [PSUM_W-1:0] bias_ext;
    logic signed [PSUM_W-1:0] base;
    logic signed [PSUM_W-1:0] wr_data;

    assign bias_ext = kernel.bias;

    // First channel starts from the bias, later channels from the old word
    assign base    = add_bias ? bias_ext : mem[addr];
    assign wr_data = mac.psum + base;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || addr_clear) begin
            addr <= '0;
        end else if (wr_en) begin
            addr <= addr + 1'b1;
        end
    end

    assign sum       = wr_data;
    assign sum_valid = emit;
    assign sum_last  = emit_last;

endmodule

/* src/act_stream_out.sv */
`timescale 1ns/1ps

module act_stream_out
    import conv_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic signed [PSUM_W-1:0] sum,
    input  logic                     sum_valid,
    input  logic                     sum_last,
    output stream_word_t             stream
);

    logic [OUT_W-1:0] clamped;
    logic [OUT_W-1:0] data_q;
    logic             valid_q;
    logic             last_q;

    // ReLU, then saturate anything above the output range
    always_comb begin
        if (sum[PSUM_W-1]) begin
            clamped = '0;
        end else if (|sum[PSUM_W-2:OUT_W]) begin
            clamped = '1;
        end else begin
            clamped = sum[OUT_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= sum_valid;
            last_q  <= sum_valid && sum_last;
        end
    end

    always_ff @(posedge clk) begin
        if (sum_valid) begin
            data_q <= clamped;
        end
    end

    assign stream = '{data: data_q, valid: valid_q, last: last_q};

endmodule

/* src/conv_pe_top.sv */
`timescale 1ns/1ps

module conv_pe_top
    import conv_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  logic [1:0]   wb_adr,
    input  bus_word_u    wb_dat_i,
    output status_t      wb_dat_o,
    output logic         wb_ack,
    output stream_word_t stream
);

    logic                     idle;
    logic                     pe_ready;
    logic                     load_kernel;
    logic                     stream_row;
    row_mode_t                row_mode;
    kernel_t                  kernel;
    pixel_beat_t              pixel;
    mac_out_t                 mac;
    logic                     wr_en;
    logic                     add_bias;
    logic                     addr_clear;
    logic                     emit;
    logic                     emit_last;
    logic signed [PSUM_W-1:0] sum;
    logic                     sum_valid;
    logic                     sum_last;

    wb_cmd_port port_i (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_i   (wb_dat_i),
        .wb_dat_o   (wb_dat_o),
        .wb_ack     (wb_ack),
        .idle       (idle),
        .pe_ready   (pe_ready),
        .load_kernel(load_kernel),
        .stream_row (stream_row),
        .row_mode   (row_mode),
        .kernel     (kernel),
        .pixel      (pixel)
    );

    row_mac mac_i (
        .clk       (clk),
        .reset     (reset),
        .pixel     (pixel),
        .kernel    (kernel),
        .stream_row(stream_row),
        .mac       (mac)
    );

    pe_buffer_ctrl ctrl_i (
        .clk        (clk),
        .reset      (reset),
        .load_kernel(load_kernel),
        .stream_row (stream_row),
        .row_mode   (row_mode),
        .mac        (mac),
        .idle       (idle),
        .pe_ready   (pe_ready),
        .wr_en      (wr_en),
        .add_bias   (add_bias),
        .addr_clear (addr_clear),
        .emit       (emit),
        .emit_last  (emit_last)
    );

    psum_buffer buf_i (
        .clk       (clk),
        .reset     (reset),
        .mac       (mac),
        .kernel    (kernel),
        .wr_en     (wr_en),
        .add_bias  (add_bias),
        .addr_clear(addr_clear),
        .emit      (emit),
        .emit_last (emit_last),
        .sum       (sum),
        .sum_valid (sum_valid),
        .sum_last  (sum_last)
    );

    act_stream_out out_i (
        .clk      (clk),
        .reset    (reset),
        .sum      (sum),
        .sum_valid(sum_valid),
        .sum_last (sum_last),
        .stream   (stream)
    );

endmodule

/* test/conv_model.svh */
`ifndef CONV_MODEL_SVH
`define CONV_MODEL_SVH

// Pixels of the channel being sent, one row per index
int chan_pix [FRAME_ROWS][ROW_IN];

// Running sum of the frame over its channels
int acc_model [OUT_DEPTH];

// First channel starts every word from its bias
function automatic void clear_accumulator(input int bias);
    for (int i = 0; i < OUT_DEPTH; i++) begin
        acc_model[i] = bias;
    end
endfunction

// 3-tap window along each row, no padding, stride 1
function automatic void accumulate_channel(input int w0, input int w1, input int w2);
    for (int r = 0; r < FRAME_ROWS; r++) begin
        for (int i = 0; i < OUT_ROW; i++) begin
            acc_model[r * OUT_ROW + i] += w0 * chan_pix[r][i] + w1 * chan_pix[r][i + 1]
                + w2 * chan_pix[r][i + 2];
        end
    end
endfunction

// ReLU then clamp to the 16-bit range
function automatic int activate(input int value);
    if (value < 0) begin
        return 0;
    end else if (value > 65535) begin
        return 65535;
    end
    return value;
endfunction

// Words leave in row-major order, the last one flagged
function automatic stream_word_t expected_word(input int index);
    stream_word_t word;
    word.data  = 16'(activate(acc_model[index]));
    word.valid = 1'b1;
    word.last  = (index == OUT_DEPTH - 1);
    return word;
endfunction

`endif

/* test/tb_conv_pe.sv */
`timescale 1ns/1ps

module tb_conv_pe
    import conv_pkg::*;
();

    localparam int N_FRAMES        = 6;
    localparam int OPS_PER_CHANNEL = 1 + FRAME_ROWS * (1 + ROW_IN / 4);
    localparam int MAX_BUS_OPS     = N_FRAMES * (4 * OPS_PER_CHANNEL + 1) + 1;
    localparam int TIMEOUT_NS      = (MAX_BUS_OPS * 20 + 16) * 4;

    logic         clk;
    logic         reset;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic [1:0]   wb_adr;
    bus_word_u    wb_dat_i;
    status_t      wb_dat_o;
    logic         wb_ack;
    stream_word_t stream;

    int           seed;
    stream_word_t got_q [$];

    `include "conv_model.svh"

    conv_pe_top dut_i (
        .clk     (clk),
        .reset   (reset),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_ack  (wb_ack),
        .stream  (stream)
    );

    always #2 clk = ~clk;

    // Sink takes every valid stream word
    always @(negedge clk) begin
        if (stream.valid) begin
            got_q.push_back(stream);
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        return lo + int'($unsigned(r) % 32'(hi - lo + 1));
    endfunction

    function automatic status_t idle_status(input logic seen);
        status_t st;
        st               = '0;
        st.idle          = 1'b1;
        st.pe_ready_seen = seen;
        return st;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_stream(input stream_word_t got, input stream_word_t exp,
                                input int index);
        if (got !== exp) begin
            stop_on_error($sformatf(
                "stream word %0d got data=%0d last=%0b, expected data=%0d last=%0b",
                index, got.data, got.last, exp.data, exp.last));
        end
    endtask

    task automatic check_status(input status_t got, input status_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("status word got %h, expected %h", got, exp));
        end
    endtask

    // Classic cycle holds the request until ack, then drops strobe
    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] data,
                             output status_t rdata);
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_i = data;
        @(negedge clk);
        while (!wb_ack) begin
            @(negedge clk);
        end
        rdata  = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] adr, input logic [31:0] data);
        status_t ignored;
        bus_cycle(1'b1, adr, data, ignored);
    endtask

    task automatic read_status(output status_t st);
        bus_cycle(1'b0, ADR_STATUS, '0, st);
    endtask

    // Send one frame over the given channels, then check stream and status
    task automatic run_frame(input int channels, input bit big, input int max_gap);
        kernel_word_t kw;
        row_cmd_t     rc;
        pixel_word_t  pw;
        status_t      st;
        int           w [3];
        int           sign;
        for (int c = 0; c < channels; c++) begin
            for (int k = 0; k < 3; k++) begin
                w[k] = big ? rand_range(96, 127) : rand_range(-128, 127);
            end
            kw.w0   = 8'(w[0]);
            kw.w1   = 8'(w[1]);
            kw.w2   = 8'(w[2]);
            kw.bias = 8'(rand_range(-128, 127));
            bus_write(ADR_KERNEL, kw);
            if (c == 0) begin
                clear_accumulator(int'(kw.bias));
            end
            // Big frames alternate the row sign to hit both clamps
            for (int r = 0; r < FRAME_ROWS; r++) begin
                sign = (r % 2 == 0) ? 1 : -1;
                for (int i = 0; i < ROW_IN; i++) begin
                    chan_pix[r][i] = big ? sign * rand_range(96, 127) : rand_range(-128, 127);
                end
            end
            accumulate_channel(w[0], w[1], w[2]);
            for (int r = 0; r < FRAME_ROWS; r++) begin
                rc               = '0;
                rc.last_row      = (r == FRAME_ROWS - 1);
                rc.first_channel = (c == 0);
                rc.last_channel  = (c == channels - 1);
                bus_write(ADR_ROW, rc);
                for (int q = 0; q < ROW_IN / 4; q++) begin
                    pw.p0 = 8'(chan_pix[r][4 * q]);
                    pw.p1 = 8'(chan_pix[r][4 * q + 1]);
                    pw.p2 = 8'(chan_pix[r][4 * q + 2]);
                    pw.p3 = 8'(chan_pix[r][4 * q + 3]);
                    repeat (rand_range(0, max_gap)) @(negedge clk);
                    bus_write(ADR_PIXELS, pw);
                end
            end
        end
        while (got_q.size() < OUT_DEPTH) begin
            @(negedge clk);
        end
        // Clear state, then idle
        repeat (2) @(negedge clk);
        read_status(st);
        check_status(st, idle_status(1'b1));
        if (got_q.size() != OUT_DEPTH) begin
            stop_on_error($sformatf("frame gave %0d stream words, expected %0d",
                got_q.size(), OUT_DEPTH));
        end
        for (int i = 0; i < OUT_DEPTH; i++) begin
            check_stream(got_q[i], expected_word(i), i);
        end
        got_q.delete();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the frames did not complete within %0d ns", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $fatal(1, "watchdog expired");
    end

    initial begin
        status_t st;
        seed     = 32'ha131;
        clk      = 1'b0;
        reset    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_i = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // No kernel yet, so the ready flag is still clear
        read_status(st);
        check_status(st, idle_status(1'b0));

        run_frame(1, 1'b0, 0);
        run_frame(rand_range(2, 4), 1'b0, 0);
        run_frame(rand_range(2, 4), 1'b0, 0);
        run_frame(4, 1'b1, 0);
        // Idle gaps between pixel writes
        run_frame(rand_range(2, 4), 1'b0, 6);
        run_frame(1, 1'b0, 6);

        $display("PASS: all tests");
        $finish;
    end

endmodule

/* build.f */
+incdir+test
src/conv_pkg.sv
src/wb_cmd_port.sv
src/row_mac.sv
src/pe_buffer_ctrl.sv
src/psum_buffer.sv
src/act_stream_out.sv
src/conv_pe_top.sv
test/tb_conv_pe.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_conv_pe -o sim_tb \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; } || exit 0
